//--- zsys.f
common/zsys_pkg.sv
hw/zsignals.sv
hw/zports.sv
zmem/zmem.sv
hw/zdata.sv
hw/zsys.sv
testbench/dram_model.sv
testbench/tb_zsys.sv

//--- Makefile
SRCS := $(shell cat zsys.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_zsys: zsys.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_zsys -f zsys.f

# passes only if the pass line appears in the output
run: obj_dir/Vtb_zsys
	./obj_dir/Vtb_zsys | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

//--- testbench/tb_zsys.sv
`default_nettype none
`timescale 1ns/100ps

module tb_zsys;

	localparam int clk_period = 100;
	localparam int rand_ops   = 200;
	// directed tests plus the random run
	localparam int num_ops    = 34 + rand_ops;

	logic                fclk = 1'b0;
	logic                rst_n;
	logic                iorq_n;
	logic                mreq_n;
	logic                rd_n;
	logic                wr_n;
	zsys_pkg::zaddr_t    a;
	zsys_pkg::zbyte_t    d_in;
	zsys_pkg::zbyte_t    d_out;
	logic                d_oe;
	logic                wait_n;
	zsys_pkg::dram_req_t dram_req;
	logic                dram_valid;
	logic                dram_ready;
	logic                dram_rvalid;
	zsys_pkg::dword_t    dram_rdata;

	zsys_pkg::dram_req_t held_req;
	zsys_pkg::dram_req_t last_req;
	logic                stalled = 1'b0;
	int                  xfer_count = 0;
	int                  valid_cycles = 0;

	zsys_pkg::page_t     win_page [4];
	zsys_pkg::zbyte_t    vals [5];
	zsys_pkg::zbyte_t    ref_mem [int];
	zsys_pkg::zaddr_t    addr;
	zsys_pkg::zbyte_t    data;
	zsys_pkg::zbyte_t    other;
	zsys_pkg::zbyte_t    got;
	logic                oe;
	int                  i;
	int                  n;
	int                  key;

	zsys #(.PORT_LO(8'hAF)) UUT (
		.fclk(fclk), .rst_n(rst_n),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a(a), .d_in(d_in), .d_out(d_out), .d_oe(d_oe), .wait_n(wait_n),
		.dram_req(dram_req), .dram_valid(dram_valid), .dram_ready(dram_ready),
		.dram_rvalid(dram_rvalid), .dram_rdata(dram_rdata)
	);

	dram_model dram (
		.fclk(fclk), .rst_n(rst_n), .req(dram_req), .valid(dram_valid),
		.ready(dram_ready), .rvalid(dram_rvalid), .rdata(dram_rdata)
	);

	always #(clk_period / 2) fclk = ~fclk;

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("[ERROR] %0t: %s", $time, msg);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	////////////////////
	// dram port monitor
	////////////////////

	always @(posedge fclk) begin
		if (stalled)
			check(dram_valid && dram_req == held_req, "dram_req changed while stalled");
		if (dram_valid)
			valid_cycles = valid_cycles + 1;
		if (dram_valid && dram_ready) begin
			xfer_count = xfer_count + 1;
			last_req   = dram_req;
		end
		stalled  = dram_valid && !dram_ready;
		held_req = dram_req;
	end

	////////////////////
	// z80 bus
	////////////////////

	task automatic bus_cycle(input logic io, input logic wr, input zsys_pkg::zaddr_t adr,
		input zsys_pkg::zbyte_t wdata, output zsys_pkg::zbyte_t rdata, output logic rd_oe);
		int waited;
		waited = 0;
		a      = adr;
		d_in   = wdata;
		iorq_n = !io;
		mreq_n = io;
		rd_n   = wr;
		wr_n   = !wr;
		while (wait_n) begin
			@(posedge fclk);
			#5;
			waited++;
		end
		check(waited <= 3, $sformatf("wait_n fell %0d cycles after the strobes", waited));
		while (!wait_n) begin
			@(posedge fclk);
			#5;
		end
		rdata  = d_out;
		rd_oe  = d_oe;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		// strobes high long enough to rearm the sampler
		repeat (3) begin
			@(posedge fclk);
			#5;
		end
	endtask

	task automatic write_port(input zsys_pkg::zaddr_t adr, input zsys_pkg::zbyte_t wdata);
		zsys_pkg::zbyte_t rdata;
		logic             rd_oe;
		bus_cycle(1'b1, 1'b1, adr, wdata, rdata, rd_oe);
	endtask

	task automatic expect_port(input zsys_pkg::zaddr_t adr, input zsys_pkg::zbyte_t exp);
		zsys_pkg::zbyte_t rdata;
		logic             rd_oe;
		bus_cycle(1'b1, 1'b0, adr, 8'h00, rdata, rd_oe);
		check(rd_oe && rdata == exp,
			$sformatf("port %h read %h oe %b, expected %h", adr, rdata, rd_oe, exp));
	endtask

	task automatic write_mem(input zsys_pkg::zaddr_t adr, input zsys_pkg::zbyte_t wdata);
		zsys_pkg::zbyte_t rdata;
		logic             rd_oe;
		bus_cycle(1'b0, 1'b1, adr, wdata, rdata, rd_oe);
	endtask

	task automatic expect_mem(input zsys_pkg::zaddr_t adr, input zsys_pkg::zbyte_t exp);
		zsys_pkg::zbyte_t rdata;
		logic             rd_oe;
		bus_cycle(1'b0, 1'b0, adr, 8'h00, rdata, rd_oe);
		check(rd_oe && rdata == exp,
			$sformatf("mem %h read %h oe %b, expected %h", adr, rdata, rd_oe, exp));
	endtask

	function automatic zsys_pkg::zaddr_t page_port(input int idx);
		return {8'h10 + 8'(idx), 8'hAF};
	endfunction

	initial begin
		#(200 * num_ops * clk_period);
		$display("timeout: the bus operations did not complete in time");
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		void'($urandom(72788));
		rst_n  = 1'b0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		a      = '0;
		d_in   = '0;
		repeat (2) @(posedge fclk);
		#5;
		rst_n = 1'b1;

		// reset values
		check(wait_n && !dram_valid && !d_oe, "outputs not idle after reset");
		expect_port(page_port(0), 8'd0);
		expect_port(page_port(1), 8'd5);
		expect_port(page_port(2), 8'd2);
		expect_port(page_port(3), 8'd0);
		expect_port(16'h21AF, 8'h01);

		// register readback
		for (i = 0; i < 5; i++) begin
			vals[i] = zsys_pkg::zbyte_t'($urandom);
			write_port(i < 4 ? page_port(i) : 16'h21AF, vals[i]);
		end
		for (i = 0; i < 5; i++)
			expect_port(i < 4 ? page_port(i) : 16'h21AF, vals[i]);

		// one write gives one request
		win_page[2] = zsys_pkg::page_t'($urandom);
		write_port(page_port(2), win_page[2]);
		addr  = 16'h8000 | (zsys_pkg::zaddr_t'($urandom) & 16'h3FFF);
		data  = zsys_pkg::zbyte_t'($urandom);
		other = zsys_pkg::zbyte_t'($urandom);
		write_mem(addr ^ 16'h0001, other);
		n = xfer_count;
		write_mem(addr, data);
		check(xfer_count == n + 1, "memory write did not give exactly one request");
		check(last_req.addr == {win_page[2], addr[13:1]} && !last_req.rnw,
			$sformatf("request address %h for cpu address %h", last_req.addr, addr));
		check(last_req.bsel == (addr[0] ? 2'b10 : 2'b01) && last_req.wdata == {data, data},
			$sformatf("request bsel %b wdata %h", last_req.bsel, last_req.wdata));
		expect_mem(addr, data);
		expect_mem(addr ^ 16'h0001, other);

		// write protect on window 0
		write_port(page_port(0), 8'h03);
		write_port(16'h21AF, 8'h00);
		write_mem(16'h0123, 8'h5A);
		write_port(16'h21AF, 8'h01);
		n = valid_cycles;
		write_mem(16'h0123, 8'hA5);
		check(valid_cycles == n, "protected write raised dram_valid");
		expect_mem(16'h0123, 8'h5A);
		write_port(16'h21AF, 8'h00);
		write_mem(16'h0123, 8'hA5);
		expect_mem(16'h0123, 8'hA5);

		// random traffic over small pages so windows alias
		for (i = 0; i < 4; i++) begin
			win_page[i] = zsys_pkg::page_t'($urandom % 6);
			write_port(page_port(i), win_page[i]);
		end
		for (i = 0; i < rand_ops; i++) begin
			addr = zsys_pkg::zaddr_t'($urandom) & 16'hC01F;
			key  = int'({win_page[addr[15:14]], addr[13:0]});
			if (($urandom % 2) == 0 || !ref_mem.exists(key)) begin
				data = zsys_pkg::zbyte_t'($urandom);
				write_mem(addr, data);
				ref_mem[key] = data;
			end else begin
				expect_mem(addr, ref_mem[key]);
			end
		end

		// foreign port
		bus_cycle(1'b1, 1'b0, 16'h10FE, 8'h00, got, oe);
		check(!oe, "read of an unselected port drove the bus");

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/dram_model.sv
`default_nettype none
`timescale 1ns/100ps

module dram_model (
	input  wire                  fclk,
	input  wire                  rst_n,
	input  zsys_pkg::dram_req_t  req,
	input  wire                  valid,
	output logic                 ready,
	output logic                 rvalid,
	output zsys_pkg::dword_t     rdata
);

	zsys_pkg::dword_t mem [int];
	zsys_pkg::dword_t rd_q [$];
	int               due_q [$];
	int               cycle;
	int               due;
	zsys_pkg::dword_t word;

	// unwritten words mix all address bits
	function automatic zsys_pkg::dword_t load(input zsys_pkg::daddr_t addr);
		if (mem.exists(int'(addr)))
			return mem[int'(addr)];
		return addr[15:0] ^ {addr[20:16], addr[20:16], addr[20:15]};
	endfunction

	always @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			ready  <= 1'b0;
			rvalid <= 1'b0;
			rdata  <= '0;
			cycle  = 0;
		end else begin
			cycle = cycle + 1;
			rvalid <= 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				rvalid <= 1'b1;
				rdata  <= rd_q.pop_front();
				void'(due_q.pop_front());
			end
			if (valid && ready) begin
				word = load(req.addr);
				if (req.rnw) begin
					// 1 to 4 cycles and kept in order
					due = cycle + 1 + int'($urandom % 4);
					if (due_q.size() > 0 && due <= due_q[$])
						due = due_q[$] + 1;
					rd_q.push_back(word);
					due_q.push_back(due);
				end else begin
					if (req.bsel[0])
						word[7:0] = req.wdata[7:0];
					if (req.bsel[1])
						word[15:8] = req.wdata[15:8];
					mem[int'(req.addr)] = word;
				end
			end
			// stall about one cycle in four
			ready <= ($urandom % 4) != 0;
		end
	end

endmodule

`default_nettype wire

//--- hw/zsys.sv
`default_nettype none
`timescale 1ns/100ps

module zsys #(
	parameter zsys_pkg::zbyte_t PORT_LO = 8'hAF
) (
	input  wire                     fclk,
	input  wire                     rst_n,

	// z80
	input  wire                     iorq_n,
	input  wire                     mreq_n,
	input  wire                     rd_n,
	input  wire                     wr_n,
	input  zsys_pkg::zaddr_t        a,
	input  zsys_pkg::zbyte_t        d_in,
	output zsys_pkg::zbyte_t        d_out,
	output logic                    d_oe,
	output logic                    wait_n,

	// dram
	output zsys_pkg::dram_req_t     dram_req,
	output logic                    dram_valid,
	input  wire                     dram_ready,
	input  wire                     dram_rvalid,
	input  zsys_pkg::dword_t        dram_rdata
);

	zsys_pkg::zcyc_t        cyc;
	logic                   cyc_valid;
	logic                   cyc_ready;
	logic                   is_io;
	logic                   io_ready;
	logic                   mem_ready;
	logic                   busy;
	logic                   idle;
	zsys_pkg::zres_t        io_res;
	logic                   io_valid;
	zsys_pkg::zres_t        mem_res;
	logic                   mem_valid;
	zsys_pkg::page_t [3:0]  pages;
	logic                   wprot;

	assign is_io     = (cyc.kind == zsys_pkg::io_rd) || (cyc.kind == zsys_pkg::io_wr);
	assign cyc_ready = io_ready | mem_ready;

	////////////////////
	// decode
	////////////////////

	zsignals zsignals (
		.fclk(fclk), .rst_n(rst_n),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a(a), .d_in(d_in),
		.cyc(cyc), .cyc_valid(cyc_valid), .cyc_ready(cyc_ready),
		.busy(busy), .idle(idle)
	);

	////////////////////
	// execute
	////////////////////

	zports #(.PORT_LO(PORT_LO)) zports (
		.fclk(fclk), .rst_n(rst_n),
		.cyc(cyc), .cyc_valid(cyc_valid && is_io), .cyc_ready(io_ready),
		.res(io_res), .res_valid(io_valid),
		.pages(pages), .wprot(wprot)
	);

	zmem z80mem (
		.fclk(fclk), .rst_n(rst_n),
		.cyc(cyc), .cyc_valid(cyc_valid && !is_io), .cyc_ready(mem_ready),
		.pages(pages), .wprot(wprot),
		.dram_req(dram_req), .dram_valid(dram_valid), .dram_ready(dram_ready),
		.dram_rvalid(dram_rvalid), .dram_rdata(dram_rdata),
		.res(mem_res), .res_valid(mem_valid)
	);

	// back toward the cpu
	zdata zdata (
		.fclk(fclk), .rst_n(rst_n),
		.busy(busy), .idle(idle),
		.io_res(io_res), .io_valid(io_valid),
		.mem_res(mem_res), .mem_valid(mem_valid),
		.d_out(d_out), .d_oe(d_oe), .wait_n(wait_n)
	);

endmodule

`default_nettype wire

//--- hw/zdata.sv
`default_nettype none
`timescale 1ns/100ps

module zdata (
	input  wire                 fclk,
	input  wire                 rst_n,

	input  wire                 busy,
	input  wire                 idle,

	input  zsys_pkg::zres_t     io_res,
	input  wire                 io_valid,
	input  zsys_pkg::zres_t     mem_res,
	input  wire                 mem_valid,

	output zsys_pkg::zbyte_t    d_out,
	output logic                d_oe,
	output logic                wait_n
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_done
	} state_t;

	state_t          state;
	zsys_pkg::zres_t res;
	logic            res_valid;

	// only one source is ever pending
	assign res_valid = io_valid || mem_valid;
	assign res       = io_valid ? io_res : mem_res;

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= st_idle;
			wait_n <= 1'b1;
			d_oe   <= 1'b0;
		end else begin
			case (state)
				st_idle:
					if (busy) begin
						state  <= st_wait;
						wait_n <= 1'b0;
					end
				st_wait:
					if (res_valid) begin
						state  <= st_done;
						wait_n <= 1'b1;
						d_oe   <= res.drive;
					end
				st_done:
					// next cycle may already be in the first sync stage
					if (idle) begin
						d_oe   <= 1'b0;
						state  <= busy ? st_wait : st_idle;
						wait_n <= ~busy;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge fclk) begin
		if (state == st_wait && res_valid)
			d_out <= res.data;
	end

endmodule

`default_nettype wire

//--- zmem/zmem.sv
`default_nettype none
`timescale 1ns/100ps

module zmem (
	input  wire                     fclk,
	input  wire                     rst_n,

	input  zsys_pkg::zcyc_t         cyc,
	input  wire                     cyc_valid,
	output logic                    cyc_ready,

	input  zsys_pkg::page_t [3:0]   pages,
	input  wire                     wprot,

	output zsys_pkg::dram_req_t     dram_req,
	output logic                    dram_valid,
	input  wire                     dram_ready,
	input  wire                     dram_rvalid,
	input  zsys_pkg::dword_t        dram_rdata,

	output zsys_pkg::zres_t         res,
	output logic                    res_valid
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait_data,
		st_done
	} state_t;

	state_t          state;
	zsys_pkg::page_t page;
	logic            is_mem;
	logic            accept;
	logic            protect;

	assign is_mem = (cyc.kind == zsys_pkg::mem_rd) || (cyc.kind == zsys_pkg::mem_wr);

	assign cyc_ready = is_mem && (state == st_idle);
	assign accept    = cyc_valid && cyc_ready;

	// window select from a15..a14
	assign page = pages[cyc.addr[15:14]];

	// window 0 stands in for rom
	assign protect = wprot && (cyc.kind == zsys_pkg::mem_wr) && (cyc.addr[15:14] == 2'b00);

	assign res_valid = (state == st_done);

	////////////////////
	// fsm
	////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			dram_valid <= 1'b0;
		end else begin
			case (state)
				st_idle:
					if (accept) begin
						if (protect) begin
							state <= st_done;
						end else begin
							state      <= st_request;
							dram_valid <= 1'b1;
						end
					end
				st_request:
					if (dram_ready) begin
						dram_valid <= 1'b0;
						state      <= dram_req.rnw ? st_wait_data : st_done;
					end
				st_wait_data:
					if (dram_rvalid)
						state <= st_done;
				default:
					state <= st_idle;
			endcase
		end
	end

	// request and result payload
	always_ff @(posedge fclk) begin
		if (accept) begin
			dram_req.addr  <= {page, cyc.addr[13:1]};
			dram_req.wdata <= {cyc.data, cyc.data};
			dram_req.bsel  <= cyc.addr[0] ? 2'b10 : 2'b01;
			dram_req.rnw   <= (cyc.kind == zsys_pkg::mem_rd);
			res.data       <= cyc.data;
			res.drive      <= 1'b0;
		end
		if (state == st_wait_data && dram_rvalid) begin
			res.data  <= dram_req.bsel[1] ? dram_rdata[15:8] : dram_rdata[7:0];
			res.drive <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/zports.sv
`default_nettype none
`timescale 1ns/100ps

module zports #(
	parameter zsys_pkg::zbyte_t PORT_LO = 8'hAF
) (
	input  wire                     fclk,
	input  wire                     rst_n,

	input  zsys_pkg::zcyc_t         cyc,
	input  wire                     cyc_valid,
	output logic                    cyc_ready,

	output zsys_pkg::zres_t         res,
	output logic                    res_valid,

	output zsys_pkg::page_t [3:0]   pages,
	output logic                    wprot
);

	zsys_pkg::zbyte_t memconf;
	zsys_pkg::zbyte_t rd_val;
	zsys_pkg::zbyte_t hi;
	logic             port_hit;
	logic             pg_hit;
	logic             mc_hit;
	logic             is_wr;
	logic             accept;

	// takes every i/o cycle without back-pressure
	assign cyc_ready = (cyc.kind == zsys_pkg::io_rd) || (cyc.kind == zsys_pkg::io_wr);
	assign accept    = cyc_valid && cyc_ready;
	assign is_wr     = (cyc.kind == zsys_pkg::io_wr);

	////////////////////
	// decode
	////////////////////

	assign hi       = cyc.addr[15:8];
	assign port_hit = (cyc.addr[7:0] == PORT_LO);

	// #10AF..#13AF
	assign pg_hit = port_hit && (hi[7:2] == 6'b000100);
	// #21AF
	assign mc_hit = port_hit && (hi == 8'h21);

	assign rd_val = pg_hit ? pages[hi[1:0]] : memconf;

	assign wprot = memconf[0];

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			pages   <= zsys_pkg::pages_rst;
			memconf <= zsys_pkg::memconf_rst;
		end else if (accept && is_wr) begin
			if (pg_hit)
				pages[hi[1:0]] <= cyc.data;
			if (mc_hit)
				memconf <= cyc.data;
		end
	end

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= accept;
	end

	// result payload
	always_ff @(posedge fclk) begin
		if (accept) begin
			res.data  <= rd_val;
			res.drive <= !is_wr && (pg_hit || mc_hit);
		end
	end

endmodule

`default_nettype wire

//--- hw/zsignals.sv
`default_nettype none
`timescale 1ns/100ps

module zsignals (
	input  wire                 fclk,
	input  wire                 rst_n,

	input  wire                 iorq_n,
	input  wire                 mreq_n,
	input  wire                 rd_n,
	input  wire                 wr_n,
	input  zsys_pkg::zaddr_t    a,
	input  zsys_pkg::zbyte_t    d_in,

	output zsys_pkg::zcyc_t     cyc,
	output logic                cyc_valid,
	input  wire                 cyc_ready,

	output logic                busy,
	output logic                idle
);

	// strobe order is iorq, mreq, rd, wr
	logic [3:0] strb_s1;
	logic [3:0] strb_s2;
	logic       pair_s1;
	logic       pair_s2;
	logic       armed;
	logic       capture;

	function automatic logic pair_on(input logic [3:0] s);
		pair_on = (~s[3] | ~s[2]) & (~s[1] | ~s[0]);
	endfunction

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			strb_s1 <= 4'b1111;
			strb_s2 <= 4'b1111;
		end else begin
			strb_s1 <= {iorq_n, mreq_n, rd_n, wr_n};
			strb_s2 <= strb_s1;
		end
	end

	assign pair_s1 = pair_on(strb_s1);
	assign pair_s2 = pair_on(strb_s2);

	assign busy = pair_s1;
	assign idle = ~pair_s2;

	// one record per strobe assertion
	assign capture = pair_s2 && armed && !cyc_valid;

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			cyc_valid <= 1'b0;
			armed     <= 1'b0;
		end else begin
			if (capture) begin
				cyc_valid <= 1'b1;
				armed     <= 1'b0;
			end else if (cyc_valid && cyc_ready) begin
				cyc_valid <= 1'b0;
			end
			if (!pair_s2)
				armed <= 1'b1;
		end
	end

	always_ff @(posedge fclk) begin
		if (capture) begin
			cyc.kind <= zsys_pkg::cyc_kind_t'({~strb_s2[3], ~strb_s2[0]});
			cyc.addr <= a;
			cyc.data <= d_in;
		end
	end

endmodule

`default_nettype wire

//--- common/zsys_pkg.sv
`default_nettype none

package zsys_pkg;

	////////////////////
	// bus widths
	////////////////////

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zbyte_t;
	typedef logic [7:0]  page_t;
	typedef logic [20:0] daddr_t;
	typedef logic [15:0] dword_t;

	// one-hot with bit 0 for the even byte
	typedef logic [1:0]  bsel_t;

	// bit 1 marks i/o and bit 0 marks writes
	typedef enum logic [1:0] {
		mem_rd = 2'b00,
		mem_wr = 2'b01,
		io_rd  = 2'b10,
		io_wr  = 2'b11
	} cyc_kind_t;

	////////////////////
	// records
	////////////////////

	typedef struct packed {
		cyc_kind_t kind;
		zaddr_t    addr;
		zbyte_t    data;
	} zcyc_t;

	typedef struct packed {
		daddr_t addr;
		dword_t wdata;
		bsel_t  bsel;
		logic   rnw;
	} dram_req_t;

	typedef struct packed {
		zbyte_t data;
		logic   drive;
	} zres_t;

	// window pages 3..0
	localparam page_t [3:0] pages_rst = {8'd0, 8'd2, 8'd5, 8'd0};
	localparam zbyte_t memconf_rst = 8'h01;

endpackage

`default_nettype wire
